// File: Makefile
# Verilator build and run of the tcb subsystem testbench

TOP = tcb_sys_tb

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tcb_sys.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// File: design/tcb_align.sv
// access aligner: lane placement and byte enables out, lane extraction of read data back
`timescale 1ns/1ps
`default_nettype none

module tcb_align
  import tcb_pkg::*;
#(
  parameter int unsigned DLY = 2
) (
  input  wire          tcb,
  input  wire          arst_n,
  // processor side request
  input  logic         req_vld,
  input  tcb_req_t     req,
  // memory side transfer
  output logic         mem_vld,
  output tcb_mem_req_t mem_req,
  // memory side response
  input  logic         mem_rsp_vld,
  input  tcb_rsp_t     mem_rsp,
  // processor side response
  output logic         rsp_vld,
  output tcb_rsp_t     rsp
);

  // side information kept until the response returns
  typedef struct packed {
    logic [1:0] off;
    tcb_siz_t   siz;
    tcb_ndn_t   ndn;
    logic       mis;
  } aln_rec_t;

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  // access size in bytes, 0 for the illegal size 3
  function automatic logic [2:0] num_of(input tcb_siz_t siz);
    return 3'(3'd1 << siz);
  endfunction

  // lane of processor byte j, big endian mirrors inside the access
  function automatic logic [1:0] lane_of(
    input logic [1:0]  off,
    input tcb_siz_t    siz,
    input tcb_ndn_t    ndn,
    input int unsigned j
  );
    logic [2:0] num;
    num = num_of(siz);
    if (ndn == TCB_BIG) begin
      return 2'(off + 2'(num - 3'd1 - 3'(j)));
    end
    return 2'(off + 2'(j));
  endfunction

  logic [2:0] req_num;
  logic       req_mis;
  aln_rec_t   rec_in;
  logic       rec_vld;
  aln_rec_t   rec_out;

  ////////////////////////////////////////
  // request path
  ////////////////////////////////////////

  assign req_num = num_of(req.siz);
  // offset bits below the access size must be zero
  assign req_mis = |(req.adr[1:0] & 2'(req_num - 3'd1));

  assign mem_vld = req_vld;

  always_comb begin
    mem_req.wen = req.wen;
    mem_req.adr = req.adr;
    mem_req.ben = '0;
    mem_req.wdt = '0;
    for (int unsigned j = 0; j < TCB_BEW; j++) begin
      if (j < req_num) begin
        mem_req.wdt[lane_of(req.adr[1:0], req.siz, req.ndn, j)] = req.wdt[8*j +: 8];
        // misaligned access keeps all lanes disabled
        mem_req.ben[lane_of(req.adr[1:0], req.siz, req.ndn, j)] = !req_mis;
      end
    end
  end

  ////////////////////////////////////////
  // alignment record delay
  ////////////////////////////////////////

  assign rec_in = '{off: req.adr[1:0], siz: req.siz, ndn: req.ndn, mis: req_mis};

  tcb_dly_line #(
    .T     (aln_rec_t),
    .DEPTH (DLY)
  ) u_rec_dly (
    .tcb     (tcb),
    .arst_n  (arst_n),
    .in_vld  (req_vld),
    .in_dat  (rec_in),
    .out_vld (rec_vld),
    .out_dat (rec_out)
  );

  ////////////////////////////////////////
  // response path
  ////////////////////////////////////////

  assign rsp_vld = mem_rsp_vld;

  always_comb begin
    rsp.err = rec_out.mis | mem_rsp.err;
    rsp.rdt = '0;
    // bytes back to LSB, upper bytes stay zero
    if (!rec_out.mis) begin
      for (int unsigned j = 0; j < TCB_BEW; j++) begin
        if (j < num_of(rec_out.siz)) begin
          rsp.rdt[8*j +: 8] =
            mem_rsp.rdt[8*lane_of(rec_out.off, rec_out.siz, rec_out.ndn, j) +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  a_siz_legal : assert property (@(posedge tcb) disable iff (!arst_n)
    req_vld |-> (req.siz <= 2'd2))
    else $error("access wider than the bus word");

  // memory latency must track the record line
  a_rsp_sync : assert property (@(posedge tcb) disable iff (!arst_n)
    mem_rsp_vld == rec_vld)
    else $error("memory response out of step with alignment record");

endmodule : tcb_align

`default_nettype wire

// File: design/tcb_dly_line.sv
// fixed depth delay line carrying a valid strobe and a typed payload
`timescale 1ns/1ps
`default_nettype none

module tcb_dly_line #(
  parameter type         T     = logic,
  parameter int unsigned DEPTH = 1
) (
  input  wire  tcb,
  input  wire  arst_n,
  input  logic in_vld,
  input  T     in_dat,
  output logic out_vld,
  output T     out_dat
);

  if (DEPTH == 0) begin : g_wire
    // zero depth degenerates to plain wires
    assign out_vld = in_vld;
    assign out_dat = in_dat;
  end else begin : g_reg
    logic [DEPTH-1:0] vld_q;
    T                 dat_q [DEPTH];

    // valid chain cleared on reset
    always_ff @(posedge tcb or negedge arst_n) begin
      if (!arst_n) begin
        vld_q <= '0;
      end else begin
        vld_q[0] <= in_vld;
        for (int unsigned i = 1; i < DEPTH; i++) begin
          vld_q[i] <= vld_q[i-1];
        end
      end
    end

    // payload moves only with its valid
    always_ff @(posedge tcb) begin
      if (in_vld) begin
        dat_q[0] <= in_dat;
      end
      for (int unsigned i = 1; i < DEPTH; i++) begin
        if (vld_q[i-1]) begin
          dat_q[i] <= dat_q[i-1];
        end
      end
    end

    assign out_vld = vld_q[DEPTH-1];
    assign out_dat = dat_q[DEPTH-1];
  end

endmodule : tcb_dly_line

`default_nettype wire

// File: design/tcb_mem.sv
// byte enabled memory subordinate with range check and fixed response delay
`timescale 1ns/1ps
`default_nettype none

module tcb_mem
  import tcb_pkg::*;
#(
  parameter int unsigned DLY    = 2,
  parameter int unsigned MEM_AW = 10
) (
  input  wire          tcb,
  input  wire          arst_n,
  input  logic         mem_vld,
  input  tcb_mem_req_t mem_req,
  output logic         mem_rsp_vld,
  output tcb_rsp_t     mem_rsp
);

  localparam int unsigned WORDS = 2**(MEM_AW-2);

  // word array, no reset on contents
  logic [TCB_BEW-1:0][7:0] mem [WORDS];

  logic              rng;
  logic [MEM_AW-3:0] idx;
  logic              rd_vld;
  tcb_rsp_t          rd_rsp;

  ////////////////////////////////////////
  // decode
  ////////////////////////////////////////

  // in range when no address bit above the array is set
  assign rng = (32'(mem_req.adr) >> MEM_AW) == 32'd0;
  assign idx = mem_req.adr[MEM_AW-1:2];

  ////////////////////////////////////////
  // array access
  ////////////////////////////////////////

  // masked write
  always_ff @(posedge tcb) begin
    if (mem_vld && mem_req.wen && rng) begin
      for (int unsigned b = 0; b < TCB_BEW; b++) begin
        if (mem_req.ben[b]) begin
          mem[idx][b] <= mem_req.wdt[b];
        end
      end
    end
  end

  // first response stage
  always_ff @(posedge tcb or negedge arst_n) begin
    if (!arst_n) begin
      rd_vld <= 1'b0;
    end else begin
      rd_vld <= mem_vld;
    end
  end

  // read data, zero for writes and out of range
  always_ff @(posedge tcb) begin
    if (mem_vld) begin
      rd_rsp.err <= !rng;
      rd_rsp.rdt <= (rng && !mem_req.wen) ? TCB_DBW'(mem[idx]) : '0;
    end
  end

  ////////////////////////////////////////
  // remaining delay
  ////////////////////////////////////////

  tcb_dly_line #(
    .T     (tcb_rsp_t),
    .DEPTH (DLY-1)
  ) u_rsp_dly (
    .tcb     (tcb),
    .arst_n  (arst_n),
    .in_vld  (rd_vld),
    .in_dat  (rd_rsp),
    .out_vld (mem_rsp_vld),
    .out_dat (mem_rsp)
  );

endmodule : tcb_mem

`default_nettype wire

// File: design/tcb_pkg.sv
// tcb bus package: widths, access size and endian types, request and response structs
`default_nettype none

package tcb_pkg;

  ////////////////////////////////////////
  // bus geometry
  ////////////////////////////////////////

  // byte address width
  localparam int unsigned TCB_ABW = 16;
  // data width
  localparam int unsigned TCB_DBW = 32;
  // byte lanes per bus word
  localparam int unsigned TCB_BEW = TCB_DBW / 8;

  ////////////////////////////////////////
  // access attributes
  ////////////////////////////////////////

  // log2 of access size in bytes, 0..2 legal
  typedef logic [1:0] tcb_siz_t;

  // byte order of the access
  typedef enum logic {
    TCB_LITTLE = 1'b0,
    TCB_BIG    = 1'b1
  } tcb_ndn_t;

  ////////////////////////////////////////
  // transfer structs
  ////////////////////////////////////////

  // processor side request, data LSB aligned
  typedef struct packed {
    logic               wen;
    tcb_ndn_t           ndn;
    tcb_siz_t           siz;
    logic [TCB_ABW-1:0] adr;
    logic [TCB_DBW-1:0] wdt;
  } tcb_req_t;

  // memory side transfer, bytes on their lanes
  typedef struct packed {
    logic                    wen;
    logic [TCB_ABW-1:0]      adr;
    logic [TCB_BEW-1:0]      ben;
    logic [TCB_BEW-1:0][7:0] wdt;
  } tcb_mem_req_t;

  // response, shared by both sides
  typedef struct packed {
    logic [TCB_DBW-1:0] rdt;
    logic               err;
  } tcb_rsp_t;

endpackage : tcb_pkg

`default_nettype wire

// File: design/tcb_sys.sv
// bus subsystem top: access aligner in front of a delayed response memory
`timescale 1ns/1ps
`default_nettype none

module tcb_sys
  import tcb_pkg::*;
#(
  parameter int unsigned DLY    = 2,
  parameter int unsigned MEM_AW = 10
) (
  input  wire      tcb,
  input  wire      arst_n,
  input  logic     req_vld,
  input  tcb_req_t req,
  output logic     rsp_vld,
  output tcb_rsp_t rsp
);

  // aligner to memory
  logic         mem_vld;
  tcb_mem_req_t mem_req;
  // memory back to aligner
  logic         mem_rsp_vld;
  tcb_rsp_t     mem_rsp;

  tcb_align #(
    .DLY (DLY)
  ) u_align (
    .tcb         (tcb),
    .arst_n      (arst_n),
    .req_vld     (req_vld),
    .req         (req),
    .mem_vld     (mem_vld),
    .mem_req     (mem_req),
    .mem_rsp_vld (mem_rsp_vld),
    .mem_rsp     (mem_rsp),
    .rsp_vld     (rsp_vld),
    .rsp         (rsp)
  );

  tcb_mem #(
    .DLY    (DLY),
    .MEM_AW (MEM_AW)
  ) u_mem (
    .tcb         (tcb),
    .arst_n      (arst_n),
    .mem_vld     (mem_vld),
    .mem_req     (mem_req),
    .mem_rsp_vld (mem_rsp_vld),
    .mem_rsp     (mem_rsp)
  );

endmodule : tcb_sys

`default_nettype wire

// File: tcb_sys.f
design/tcb_pkg.sv
design/tcb_dly_line.sv
design/tcb_align.sv
design/tcb_mem.sv
design/tcb_sys.sv
tests/tcb_sys_tb.sv

// File: tests/tcb_sys_tb.sv
// tcb subsystem testbench checking a table of accesses against a byte array reference model
`timescale 1ns/1ps
`default_nettype none

module tcb_sys_tb
  import tcb_pkg::*;
();

  localparam int unsigned DLY       = 2;
  localparam int unsigned MEM_AW    = 10;
  localparam int unsigned MEM_BYTES = 1 << MEM_AW;
  localparam int unsigned TIMEOUT   = 50;

  // one table row
  typedef struct packed {
    tcb_req_t    req;
    logic        wt;   // drain responses before the next row
    logic [31:0] rdt;
    logic        err;
  } entry_t;

  // expected response and the cycle it must show up in
  typedef struct {
    logic [31:0] rdt;
    logic        err;
    int          cyc;
  } rsp_exp_t;

  logic     tcb;
  logic     arst_n;
  logic     req_vld;
  tcb_req_t req;
  logic     rsp_vld;
  tcb_rsp_t rsp;

  entry_t      tbl [$];
  rsp_exp_t    exp_q [$];
  logic [7:0]  ref_mem [MEM_BYTES];
  int          cyc;
  int          errors;
  bit          ok;

  tcb_sys #(
    .DLY    (DLY),
    .MEM_AW (MEM_AW)
  ) dut (
    .tcb     (tcb),
    .arst_n  (arst_n),
    .req_vld (req_vld),
    .req     (req),
    .rsp_vld (rsp_vld),
    .rsp     (rsp)
  );

  ////////////////////////////////////////
  // clock and cycle count
  ////////////////////////////////////////

  initial begin
    tcb = 1'b0;
    forever #4 tcb = ~tcb;
  end

  always @(posedge tcb) begin
    cyc <= cyc + 1;
  end

  ////////////////////////////////////////
  // reference model and table build
  ////////////////////////////////////////

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      errors++;
      $display("[FAIL] %0t ns: %s got %h expected %h", $time, what, got, want);
    end
  endtask

  function automatic tcb_req_t mk_req(input logic wen, input tcb_ndn_t ndn,
                                      input tcb_siz_t siz, input logic [15:0] adr,
                                      input logic [31:0] wdt);
    tcb_req_t r;
    r.wen = wen;
    r.ndn = ndn;
    r.siz = siz;
    r.adr = adr;
    r.wdt = wdt;
    return r;
  endfunction

  // processor byte j sits at adr+j in memory and mirrored within the access for big endian
  task automatic model_access(input tcb_req_t r, output logic [31:0] rdt, output logic err);
    int unsigned num;
    int unsigned a;
    num = 1 << r.siz;
    rdt = '0;
    err = 1'b0;
    if ((32'(r.adr) % num) != 0 || 32'(r.adr) >= MEM_BYTES) begin
      err = 1'b1;
    end else begin
      for (int unsigned j = 0; j < num; j++) begin
        a = (r.ndn == TCB_BIG) ? 32'(r.adr) + num - 1 - j : 32'(r.adr) + j;
        if (r.wen) begin
          ref_mem[a] = r.wdt[8*j +: 8];
        end else begin
          rdt[8*j +: 8] = ref_mem[a];
        end
      end
    end
  endtask

  // directed row with hand written expected values while the model stays in step
  task automatic push_directed(input tcb_req_t r, input logic [31:0] rdt, input logic err);
    entry_t      e;
    logic [31:0] m_rdt;
    logic        m_err;
    model_access(r, m_rdt, m_err);
    e.req = r;
    e.wt  = 1'b1;
    e.rdt = rdt;
    e.err = err;
    tbl.push_back(e);
  endtask

  // random row within the first four words with expected values from the model
  task automatic push_random(input logic wt);
    entry_t      e;
    tcb_req_t    r;
    logic [31:0] m_rdt;
    logic        m_err;
    r.wen = 1'($urandom_range(1, 0));
    r.ndn = tcb_ndn_t'($urandom_range(1, 0));
    r.siz = tcb_siz_t'($urandom_range(2, 0));
    r.adr = 16'($urandom_range(15, 0));
    r.wdt = $urandom;
    model_access(r, m_rdt, m_err);
    e.req = r;
    e.wt  = wt;
    e.rdt = m_rdt;
    e.err = m_err;
    tbl.push_back(e);
  endtask

  ////////////////////////////////////////
  // driver and response monitor
  ////////////////////////////////////////

  task automatic wait_drain(output bit done);
    int unsigned t;
    t = 0;
    while (exp_q.size() != 0 && t < TIMEOUT) begin
      @(posedge tcb);
      t++;
    end
    done = (exp_q.size() == 0);
  endtask

  task automatic apply_table(output bit done);
    rsp_exp_t x;
    done = 1'b1;
    foreach (tbl[i]) begin
      @(negedge tcb);
      req_vld = 1'b1;
      req     = tbl[i].req;
      x.rdt   = tbl[i].rdt;
      x.err   = tbl[i].err;
      x.cyc   = cyc + DLY;
      exp_q.push_back(x);
      if (tbl[i].wt) begin
        @(negedge tcb);
        req_vld = 1'b0;
        wait_drain(done);
        if (!done) begin
          return;
        end
      end
    end
  endtask

  // each response is matched to the oldest expected one and its due cycle
  always @(negedge tcb) begin
    if (rsp_vld !== 1'b0) begin
      if (exp_q.size() == 0) begin
        check("rsp_vld while idle", 32'(rsp_vld), 32'd0);
      end else begin
        check("rsp_vld", 32'(rsp_vld), 32'd1);
        check("rsp cycle", 32'(cyc), 32'(exp_q[0].cyc));
        check("rsp.rdt", rsp.rdt, exp_q[0].rdt);
        check("rsp.err", 32'(rsp.err), 32'(exp_q[0].err));
        void'(exp_q.pop_front());
      end
    end
  end

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    arst_n  = 1'b0;
    req_vld = 1'b0;
    req     = '0;
    cyc     = 0;
    errors  = 0;
    void'($urandom(32'h439c8168));

    // word write read back whole and in pieces
    push_directed(mk_req(1'b1, TCB_LITTLE, 2'd2, 16'h0000, 32'h4433_2211), 32'h0, 1'b0);
    push_directed(mk_req(1'b0, TCB_LITTLE, 2'd2, 16'h0000, 32'h0), 32'h4433_2211, 1'b0);
    push_directed(mk_req(1'b0, TCB_LITTLE, 2'd0, 16'h0000, 32'h0), 32'h0000_0011, 1'b0);
    push_directed(mk_req(1'b0, TCB_LITTLE, 2'd0, 16'h0001, 32'h0), 32'h0000_0022, 1'b0);
    push_directed(mk_req(1'b0, TCB_LITTLE, 2'd0, 16'h0002, 32'h0), 32'h0000_0033, 1'b0);
    push_directed(mk_req(1'b0, TCB_LITTLE, 2'd0, 16'h0003, 32'h0), 32'h0000_0044, 1'b0);
    push_directed(mk_req(1'b0, TCB_LITTLE, 2'd1, 16'h0000, 32'h0), 32'h0000_2211, 1'b0);
    push_directed(mk_req(1'b0, TCB_LITTLE, 2'd1, 16'h0002, 32'h0), 32'h0000_4433, 1'b0);
    // big endian writes read back in both orders
    push_directed(mk_req(1'b1, TCB_BIG, 2'd1, 16'h0004, 32'h0000_aabb), 32'h0, 1'b0);
    push_directed(mk_req(1'b1, TCB_BIG, 2'd2, 16'h0008, 32'h1234_5678), 32'h0, 1'b0);
    push_directed(mk_req(1'b0, TCB_LITTLE, 2'd1, 16'h0004, 32'h0), 32'h0000_bbaa, 1'b0);
    push_directed(mk_req(1'b0, TCB_LITTLE, 2'd2, 16'h0008, 32'h0), 32'h7856_3412, 1'b0);
    push_directed(mk_req(1'b0, TCB_BIG, 2'd1, 16'h0004, 32'h0), 32'h0000_aabb, 1'b0);
    push_directed(mk_req(1'b0, TCB_BIG, 2'd2, 16'h0008, 32'h0), 32'h1234_5678, 1'b0);
    // misaligned accesses leave the memory unchanged
    push_directed(mk_req(1'b1, TCB_LITTLE, 2'd1, 16'h0001, 32'h0000_ffff), 32'h0, 1'b1);
    push_directed(mk_req(1'b1, TCB_LITTLE, 2'd2, 16'h0002, 32'hffff_ffff), 32'h0, 1'b1);
    push_directed(mk_req(1'b0, TCB_LITTLE, 2'd1, 16'h0003, 32'h0), 32'h0, 1'b1);
    push_directed(mk_req(1'b0, TCB_BIG, 2'd2, 16'h0001, 32'h0), 32'h0, 1'b1);
    push_directed(mk_req(1'b0, TCB_LITTLE, 2'd2, 16'h0000, 32'h0), 32'h4433_2211, 1'b0);
    // beyond the memory
    push_directed(mk_req(1'b1, TCB_LITTLE, 2'd2, 16'h0400, 32'hdead_beef), 32'h0, 1'b1);
    push_directed(mk_req(1'b0, TCB_LITTLE, 2'd2, 16'h0400, 32'h0), 32'h0, 1'b1);
    push_directed(mk_req(1'b0, TCB_LITTLE, 2'd0, 16'hffff, 32'h0), 32'h0, 1'b1);
    // word 0 must not see the out of range write
    push_directed(mk_req(1'b0, TCB_LITTLE, 2'd2, 16'h0000, 32'h0), 32'h4433_2211, 1'b0);
    // fill the rest of words 0..3 so every burst read is known
    push_directed(mk_req(1'b1, TCB_LITTLE, 2'd1, 16'h0006, 32'h0000_cdef), 32'h0, 1'b0);
    push_directed(mk_req(1'b1, TCB_LITTLE, 2'd2, 16'h000c, 32'h0bad_f00d), 32'h0, 1'b0);
    // back to back burst drained after the last request
    for (int i = 0; i < 16; i++) begin
      push_random(i == 15);
    end

    // reset held for 10 cycles
    repeat (10) @(posedge tcb);
    @(negedge tcb);
    arst_n = 1'b1;

    apply_table(ok);
    if (!ok) begin
      errors++;
      $display("timed out waiting for a response, %0d still outstanding", exp_q.size());
    end

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule : tcb_sys_tb

`default_nettype wire
